/* verilog/llki_pkg.sv */
/* LLKI protocol processor definitions
   Widths, register map, message and status codes, FSM states and port structs */
package llki_pkg;

  // ------------------------------
  // Widths and register map
  // ------------------------------
  // Host bus and key word width
  localparam int LLKI_DATA_W = 64;
  localparam int LLKI_ADDR_W = 32;
  // ID and status fields share one width
  localparam int LLKI_FIELD_W = 8;
  localparam int LLKI_LEN_W = 16;
  // Only the ready and response bits exist in control/status
  localparam int LLKI_CTRLSTS_W = 2;

  localparam logic [LLKI_ADDR_W-1:0] LLKI_CTRLSTS_ADDR = 32'h0000_0000;
  localparam logic [LLKI_ADDR_W-1:0] LLKI_SENDRECV_ADDR = 32'h0000_0008;

  // Control/status bit positions
  localparam int LLKI_CTRLSTS_READY_BIT = 0;
  localparam int LLKI_CTRLSTS_RESP_BIT = 1;

  // Message word layout, upper bits are zero
  localparam int LLKI_MSG_ID_LSB = 0;
  localparam int LLKI_STATUS_LSB = 8;
  localparam int LLKI_LEN_LSB = 16;

  // ------------------------------
  // Message and status codes
  // ------------------------------
  typedef enum logic [LLKI_FIELD_W-1:0] {
    LOAD_KEY_REQ    = 8'h00,
    CLEAR_KEY_REQ   = 8'h01,
    KEY_STATUS_REQ  = 8'h02,
    LOAD_KEY_ACK    = 8'h03,
    CLEAR_KEY_ACK   = 8'h04,
    KEY_STATUS_RESP = 8'h05,
    ERROR_RESP      = 8'h06
  } llki_msg_id_e;

  typedef enum logic [LLKI_FIELD_W-1:0] {
    GOOD            = 8'h00,
    KEY_PRESENT     = 8'h01,
    KEY_NOT_PRESENT = 8'h02,
    BAD_MSG_ID      = 8'h20,
    BAD_MSG_LEN     = 8'h21,
    KEY_OVERWRITE   = 8'h22,
    BAD_KEY_LEN     = 8'h23,
    LOSS_OF_SYNC    = 8'h24
  } llki_status_e;

  // Protocol FSM states
  typedef enum logic [2:0] {
    IDLE,
    MSG_CHECK,
    LOAD_WORDS,
    WAIT_COMPLETE,
    CLEAR_KEY,
    RESPONSE
  } llki_state_e;

  // ------------------------------
  // Port structs
  // ------------------------------
  // Host register strobes, one cycle each
  typedef struct packed {
    logic                   we;
    logic                   re;
    logic [LLKI_ADDR_W-1:0] addr;
    logic [LLKI_DATA_W-1:0] wdata;
  } llki_bus_req_t;

  typedef struct packed {
    logic                   ack;
    logic                   error;
    logic [LLKI_DATA_W-1:0] rdata;
  } llki_bus_rsp_t;

  // Key port toward the core
  typedef struct packed {
    logic [LLKI_DATA_W-1:0] key_data;
    logic                   key_valid;
    logic                   clear_key;
  } llki_key_cmd_t;

  // Levels from the core
  typedef struct packed {
    logic key_ready;
    logic key_complete;
    logic clear_ack;
  } llki_key_sts_t;

  // Send/receive events from decoder to FSM
  typedef struct packed {
    logic                   sr_wr;
    logic                   sr_rd;
    logic [LLKI_DATA_W-1:0] wdata;
  } llki_msg_evt_t;

  // Single response buffer from FSM to decoder
  typedef struct packed {
    logic                   waiting;
    logic [LLKI_DATA_W-1:0] word;
  } llki_resp_t;

endpackage

/* verilog/llki_reg_decode.sv */
/* LLKI register decoder
   Maps host strobes onto control/status and send/receive, answers one cycle later */
module llki_reg_decode (
  input  logic                    clk,
  input  logic                    rst,
  input  llki_pkg::llki_bus_req_t bus_req_i,
  output llki_pkg::llki_bus_rsp_t bus_rsp_o,
  input  logic                    key_ready_i,
  input  llki_pkg::llki_resp_t    resp_i,
  output llki_pkg::llki_msg_evt_t msg_evt_o
);
  import llki_pkg::*;

  logic                      strobe;
  logic                      hit_ctrlsts;
  logic                      hit_sendrecv;
  // Read-only status bits, sampled every cycle
  logic [LLKI_CTRLSTS_W-1:0] ctrlsts_q;
  llki_bus_rsp_t             rsp_d;
  llki_bus_rsp_t             rsp_q;

  // ------------------------------
  // Address decode
  // ------------------------------
  assign strobe       = bus_req_i.we || bus_req_i.re;
  assign hit_ctrlsts  = (bus_req_i.addr == LLKI_CTRLSTS_ADDR);
  assign hit_sendrecv = (bus_req_i.addr == LLKI_SENDRECV_ADDR);

  // Send/receive accesses go straight to the FSM in the strobe cycle
  assign msg_evt_o.sr_wr = bus_req_i.we && hit_sendrecv;
  assign msg_evt_o.sr_rd = bus_req_i.re && hit_sendrecv;
  assign msg_evt_o.wdata = bus_req_i.wdata;

  // ------------------------------
  // Response formation
  // ------------------------------
  always_comb begin
    rsp_d = '0;
    // Every strobe is acknowledged
    rsp_d.ack = strobe;
    // Unmapped address on either access type
    rsp_d.error = strobe && !(hit_ctrlsts || hit_sendrecv);
    if (bus_req_i.re) begin
      if (hit_ctrlsts) begin
        // Status bits as they stood the cycle before
        rsp_d.rdata[LLKI_CTRLSTS_W-1:0] = ctrlsts_q;
      end else if (hit_sendrecv) begin
        // Zero unless a response is buffered
        rsp_d.rdata = resp_i.word;
      end
    end
  end

  // ------------------------------
  // Registers
  // ------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rsp_q     <= '0;
      ctrlsts_q <= '0;
    end else begin
      // Ack, error and read data land one cycle after the strobe
      rsp_q <= rsp_d;
      // Ready for next key word, as seen from the core
      ctrlsts_q[LLKI_CTRLSTS_READY_BIT] <= key_ready_i;
      // Response-waiting trails the FSM buffer by a cycle
      ctrlsts_q[LLKI_CTRLSTS_RESP_BIT]  <= resp_i.waiting;
    end
  end

  assign bus_rsp_o = rsp_q;

endmodule

/* verilog/llki_msg_fsm.sv */
/* LLKI protocol FSM
   Checks requests, forwards key words, clears keys and buffers one response */
module llki_msg_fsm (
  input  logic                    clk,
  input  logic                    rst,
  input  llki_pkg::llki_msg_evt_t msg_evt_i,
  input  llki_pkg::llki_key_sts_t key_sts_i,
  output llki_pkg::llki_key_cmd_t key_cmd_o,
  output llki_pkg::llki_resp_t    resp_o
);
  import llki_pkg::*;

  llki_state_e            state_q;
  llki_state_e            state_d;
  // Request header, rewritten in place into the response header
  llki_msg_id_e           msg_id_q;
  llki_msg_id_e           msg_id_d;
  llki_status_e           status_q;
  llki_status_e           status_d;
  // Remaining length, header included
  logic [LLKI_LEN_W-1:0]  len_q;
  logic [LLKI_LEN_W-1:0]  len_d;
  // Key port
  logic                   key_valid_q;
  logic                   key_valid_d;
  logic [LLKI_DATA_W-1:0] key_data_q;
  logic [LLKI_DATA_W-1:0] key_data_d;
  logic                   clear_key_q;
  // Response buffer
  logic                   waiting_q;
  logic                   waiting_d;
  logic [LLKI_DATA_W-1:0] word_q;
  logic [LLKI_DATA_W-1:0] word_d;
  logic [LLKI_DATA_W-1:0] resp_word;

  // ------------------------------
  // Response word
  // ------------------------------
  // Every response has length 1
  always_comb begin
    resp_word = '0;
    resp_word[LLKI_MSG_ID_LSB +: LLKI_FIELD_W] = msg_id_q;
    resp_word[LLKI_STATUS_LSB +: LLKI_FIELD_W] = status_q;
    resp_word[LLKI_LEN_LSB +: LLKI_LEN_W]      = LLKI_LEN_W'(1);
  end

  // ------------------------------
  // Next state
  // ------------------------------
  always_comb begin
    state_d     = state_q;
    msg_id_d    = msg_id_q;
    status_d    = status_q;
    len_d       = len_q;
    // Key port idles at zero between pulses
    key_valid_d = 1'b0;
    key_data_d  = '0;
    // Buffer is empty outside RESPONSE
    waiting_d   = 1'b0;
    word_d      = '0;

    case (state_q)
      IDLE: begin
        // Capture the request header
        if (msg_evt_i.sr_wr) begin
          msg_id_d = llki_msg_id_e'(msg_evt_i.wdata[LLKI_MSG_ID_LSB +: LLKI_FIELD_W]);
          status_d = llki_status_e'(msg_evt_i.wdata[LLKI_STATUS_LSB +: LLKI_FIELD_W]);
          len_d    = msg_evt_i.wdata[LLKI_LEN_LSB +: LLKI_LEN_W];
          state_d  = MSG_CHECK;
        end
      end

      MSG_CHECK: begin
        // Single-cycle decision on the captured header
        state_d = RESPONSE;
        case (msg_id_q)
          LOAD_KEY_REQ: begin
            if (len_q <= LLKI_LEN_W'(1)) begin
              // A load needs at least one key word
              msg_id_d = ERROR_RESP;
              status_d = BAD_MSG_LEN;
            end else if (key_sts_i.key_complete) begin
              // Existing key must be cleared first
              msg_id_d = ERROR_RESP;
              status_d = KEY_OVERWRITE;
            end else begin
              state_d = LOAD_WORDS;
            end
          end
          CLEAR_KEY_REQ: begin
            if (len_q != LLKI_LEN_W'(1)) begin
              msg_id_d = ERROR_RESP;
              status_d = BAD_MSG_LEN;
            end else begin
              state_d = CLEAR_KEY;
            end
          end
          KEY_STATUS_REQ: begin
            if (len_q != LLKI_LEN_W'(1)) begin
              msg_id_d = ERROR_RESP;
              status_d = BAD_MSG_LEN;
            end else begin
              msg_id_d = KEY_STATUS_RESP;
              status_d = key_sts_i.key_complete ? KEY_PRESENT : KEY_NOT_PRESENT;
            end
          end
          default: begin
            msg_id_d = ERROR_RESP;
            status_d = BAD_MSG_ID;
          end
        endcase
      end

      LOAD_WORDS: begin
        // Host checks ready for key before each word
        if (msg_evt_i.sr_wr) begin
          if (!key_sts_i.key_ready) begin
            // Word dropped, core not ready
            msg_id_d = ERROR_RESP;
            status_d = LOSS_OF_SYNC;
            state_d  = RESPONSE;
          end else if (key_sts_i.key_complete) begin
            // Key longer than the core expects, wipe it
            msg_id_d = ERROR_RESP;
            status_d = BAD_KEY_LEN;
            state_d  = CLEAR_KEY;
          end else begin
            key_valid_d = 1'b1;
            key_data_d  = msg_evt_i.wdata;
            if (len_q == LLKI_LEN_W'(2)) begin
              // Last word, wait for the core to finish
              msg_id_d = LOAD_KEY_ACK;
              status_d = GOOD;
              state_d  = WAIT_COMPLETE;
            end else begin
              len_d = len_q - LLKI_LEN_W'(1);
            end
          end
        end
      end

      WAIT_COMPLETE: begin
        if (key_sts_i.key_complete) begin
          state_d = RESPONSE;
        end
      end

      CLEAR_KEY: begin
        if (key_sts_i.clear_ack) begin
          // Error path keeps its ID and status
          if (msg_id_q != ERROR_RESP) begin
            msg_id_d = CLEAR_KEY_ACK;
            status_d = GOOD;
          end
          state_d = RESPONSE;
        end
      end

      RESPONSE: begin
        // Read of send/receive releases the buffer
        if (msg_evt_i.sr_rd) begin
          state_d = IDLE;
        end else begin
          waiting_d = 1'b1;
          word_d    = resp_word;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // ------------------------------
  // Registers
  // ------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q     <= IDLE;
      msg_id_q    <= LOAD_KEY_REQ;
      status_q    <= GOOD;
      len_q       <= '0;
      key_valid_q <= 1'b0;
      clear_key_q <= 1'b0;
      waiting_q   <= 1'b0;
      word_q      <= '0;
    end else begin
      state_q     <= state_d;
      msg_id_q    <= msg_id_d;
      status_q    <= status_d;
      len_q       <= len_d;
      key_valid_q <= key_valid_d;
      // High for exactly the cycles spent in CLEAR_KEY
      clear_key_q <= (state_d == CLEAR_KEY);
      waiting_q   <= waiting_d;
      word_q      <= word_d;
    end
  end

  // Key word payload
  always_ff @(posedge clk) begin
    key_data_q <= key_data_d;
  end

  assign key_cmd_o.key_data  = key_data_q;
  assign key_cmd_o.key_valid = key_valid_q;
  assign key_cmd_o.clear_key = clear_key_q;

  assign resp_o.waiting = waiting_q;
  assign resp_o.word    = word_q;

endmodule

/* verilog/llki_pp.sv */
/* LLKI protocol processor
   Host register interface on one side, key-loading port of a keyed core on the other */
module llki_pp (
  input  logic                    clk,
  input  logic                    rst,
  // Host register bus
  input  llki_pkg::llki_bus_req_t bus_req_i,
  output llki_pkg::llki_bus_rsp_t bus_rsp_o,
  // Key port
  input  llki_pkg::llki_key_sts_t key_sts_i,
  output llki_pkg::llki_key_cmd_t key_cmd_o
);
  import llki_pkg::*;

  // Send/receive strobes toward the FSM
  llki_msg_evt_t msg_evt;
  // Buffered response back to the decoder
  llki_resp_t    resp;

  // ------------------------------
  // Register decode
  // ------------------------------
  llki_reg_decode u_reg_decode (
    .clk         (clk),
    .rst         (rst),
    .bus_req_i   (bus_req_i),
    .bus_rsp_o   (bus_rsp_o),
    // Feeds the ready-for-key status bit
    .key_ready_i (key_sts_i.key_ready),
    .resp_i      (resp),
    .msg_evt_o   (msg_evt)
  );

  // ------------------------------
  // Protocol FSM
  // ------------------------------
  llki_msg_fsm u_msg_fsm (
    .clk       (clk),
    .rst       (rst),
    .msg_evt_i (msg_evt),
    .key_sts_i (key_sts_i),
    .key_cmd_o (key_cmd_o),
    .resp_o    (resp)
  );

endmodule

/* tests/llki_pp_props.sv */
/* LLKI protocol processor properties
   Bus acknowledge timing and key-port pulse rules, bound to the top level */
module llki_pp_props (
  input logic                    clk,
  input logic                    rst,
  input llki_pkg::llki_bus_req_t bus_req_i,
  input llki_pkg::llki_bus_rsp_t bus_rsp_i,
  input llki_pkg::llki_key_cmd_t key_cmd_i
);
  timeunit 1ns;
  timeprecision 1ps;

  logic strobe;
  // Count of failed properties
  int   assert_fail_cnt = 0;

  assign strobe = bus_req_i.we || bus_req_i.re;

  // ------------------------------
  // Host bus
  // ------------------------------
  // Ack lands exactly one cycle after each strobe
  ack_follows_strobe: assert property (@(posedge clk) disable iff (rst)
    strobe |=> bus_rsp_i.ack)
    else begin
      $error("ack missing one cycle after a strobe");
      assert_fail_cnt++;
    end
  no_ack_without_strobe: assert property (@(posedge clk) disable iff (rst)
    !strobe |=> !bus_rsp_i.ack)
    else begin
      $error("ack without a strobe the cycle before");
      assert_fail_cnt++;
    end
  // Error only qualifies an ack
  error_only_with_ack: assert property (@(posedge clk) disable iff (rst)
    bus_rsp_i.error |-> bus_rsp_i.ack)
    else begin
      $error("error raised without ack");
      assert_fail_cnt++;
    end
  rdata_zero_when_idle: assert property (@(posedge clk) disable iff (rst)
    !bus_rsp_i.ack |-> (bus_rsp_i.rdata == '0))
    else begin
      $error("rdata not zero between acks");
      assert_fail_cnt++;
    end

  // ------------------------------
  // Key port
  // ------------------------------
  key_valid_one_cycle: assert property (@(posedge clk) disable iff (rst)
    key_cmd_i.key_valid |=> !key_cmd_i.key_valid)
    else begin
      $error("key_valid held past one cycle");
      assert_fail_cnt++;
    end
  key_data_zero_when_idle: assert property (@(posedge clk) disable iff (rst)
    !key_cmd_i.key_valid |-> (key_cmd_i.key_data == '0))
    else begin
      $error("key_data not zero");
      assert_fail_cnt++;
    end
  clear_excludes_valid: assert property (@(posedge clk) disable iff (rst)
    !(key_cmd_i.clear_key && key_cmd_i.key_valid))
    else begin
      $error("clear_key with key_valid");
      assert_fail_cnt++;
    end

  // Everything quiet while reset is held
  outputs_low_in_reset: assert property (@(posedge clk)
    rst |-> !bus_rsp_i.ack && !bus_rsp_i.error && !key_cmd_i.key_valid && !key_cmd_i.clear_key)
    else begin
      $error("outputs active during reset");
      assert_fail_cnt++;
    end

endmodule

bind llki_pp llki_pp_props u_props (
  .clk       (clk),
  .rst       (rst),
  .bus_req_i (bus_req_i),
  .bus_rsp_i (bus_rsp_o),
  .key_cmd_i (key_cmd_o)
);

/* tests/llki_pp_tb.sv */
/* LLKI protocol processor testbench
   Host message sequences against a two-word key-store model of the core */
module llki_pp_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import llki_pkg::*;

  localparam int CLK_PERIOD      = 20;
  localparam int RESET_CYCLES    = 4;
  // Key length in words that the core model expects
  localparam int KEY_WORDS       = 2;
  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 400;
  localparam int POLL_LIMIT      = 100;
  localparam logic [LLKI_ADDR_W-1:0] UNMAPPED_ADDR = 32'h0000_0010;
  // Not a defined request ID
  localparam logic [7:0] UNKNOWN_ID = 8'h07;

  logic          clk;
  logic          rst;
  llki_bus_req_t bus_req;
  llki_bus_rsp_t bus_rsp;
  llki_key_sts_t key_sts;
  llki_key_cmd_t key_cmd;

  // Key-store model state
  logic                   ready_en     = 1'b1;
  logic                   complete_q   = 1'b0;
  logic                   clear_ack_q  = 1'b0;
  int                     word_cnt     = 0;
  int                     settle_cnt   = 0;
  int                     clear_wait   = 0;
  int                     clear_events = 0;
  // All key words seen on the port in order
  logic [LLKI_DATA_W-1:0] seen_words[$];

  int err_cnt       = 0;
  int fail_cnt      = 0;
  int test_cnt      = 0;
  int test_err_base = 0;

  llki_pp dut_i (
    .clk       (clk),
    .rst       (rst),
    .bus_req_i (bus_req),
    .bus_rsp_o (bus_rsp),
    .key_sts_i (key_sts),
    .key_cmd_o (key_cmd)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ------------------------------
  // Key-store model
  // ------------------------------
  assign key_sts.key_ready    = ready_en;
  assign key_sts.key_complete = complete_q;
  assign key_sts.clear_ack    = clear_ack_q;

  always @(negedge clk) begin
    if (rst) begin
      complete_q  <= 1'b0;
      clear_ack_q <= 1'b0;
      word_cnt    <= 0;
      settle_cnt  <= 0;
      clear_wait  <= 0;
    end else begin
      // Key settles 3 cycles after its last word
      if (settle_cnt == 1) begin
        complete_q <= 1'b1;
      end
      if (settle_cnt != 0) begin
        settle_cnt <= settle_cnt - 1;
      end
      if (key_cmd.key_valid) begin
        seen_words.push_back(key_cmd.key_data);
        word_cnt <= word_cnt + 1;
        if (word_cnt == KEY_WORDS - 1) begin
          settle_cnt <= 3;
        end
      end
      // Clear ack two cycles into clear_key wipes the key
      if (!key_cmd.clear_key) begin
        clear_ack_q <= 1'b0;
        clear_wait  <= 0;
      end else if (!clear_ack_q) begin
        if (clear_wait == 2) begin
          clear_ack_q  <= 1'b1;
          complete_q   <= 1'b0;
          word_cnt     <= 0;
          settle_cnt   <= 0;
          clear_events <= clear_events + 1;
        end else begin
          clear_wait <= clear_wait + 1;
        end
      end
    end
  end

  // ------------------------------
  // Host helpers
  // ------------------------------
  function automatic void report_mismatch(input string msg);
    $display("Mismatch at %0t ns: %s", $time, msg);
    err_cnt++;
  endfunction

  // Testbench errors plus failed bound properties
  function automatic int total_errors();
    return err_cnt + dut_i.u_props.assert_fail_cnt;
  endfunction

  // Header layout with ID in 7..0, status in 15..8 and length in 31..16
  function automatic logic [LLKI_DATA_W-1:0] make_hdr(input logic [7:0] id,
      input logic [7:0] status, input logic [LLKI_LEN_W-1:0] len);
    logic [LLKI_DATA_W-1:0] word;
    word = '0;
    word[LLKI_MSG_ID_LSB +: 8] = id;
    word[LLKI_STATUS_LSB +: 8] = status;
    word[LLKI_LEN_LSB +: LLKI_LEN_W] = len;
    return word;
  endfunction

  function automatic logic [LLKI_DATA_W-1:0] ctrlsts_word(input logic ready, input logic resp);
    logic [LLKI_DATA_W-1:0] word;
    word = '0;
    word[LLKI_CTRLSTS_READY_BIT] = ready;
    word[LLKI_CTRLSTS_RESP_BIT]  = resp;
    return word;
  endfunction

  // Tasks start and end just after a falling edge; writes leave one idle cycle
  task automatic bus_write(input logic [LLKI_ADDR_W-1:0] addr,
      input logic [LLKI_DATA_W-1:0] data, input logic exp_err);
    bus_req.we    = 1'b1;
    bus_req.addr  = addr;
    bus_req.wdata = data;
    @(negedge clk);
    bus_req = '0;
    assert (bus_rsp.ack && bus_rsp.error == exp_err)
      else report_mismatch($sformatf("write to %h, ack %b error %b", addr,
        bus_rsp.ack, bus_rsp.error));
    @(negedge clk);
  endtask

  task automatic bus_read(input logic [LLKI_ADDR_W-1:0] addr, input logic exp_err,
      output logic [LLKI_DATA_W-1:0] data);
    bus_req.re   = 1'b1;
    bus_req.addr = addr;
    @(negedge clk);
    bus_req = '0;
    data    = bus_rsp.rdata;
    assert (bus_rsp.ack && bus_rsp.error == exp_err)
      else report_mismatch($sformatf("read of %h, ack %b error %b", addr,
        bus_rsp.ack, bus_rsp.error));
  endtask

  task automatic send_msg(input logic [7:0] id, input logic [LLKI_LEN_W-1:0] len);
    bus_write(LLKI_SENDRECV_ADDR, make_hdr(id, 8'h00, len), 1'b0);
  endtask

  // Poll the response-waiting bit
  task automatic wait_response();
    logic [LLKI_DATA_W-1:0] rd;
    int                     polls;
    rd    = '0;
    polls = 0;
    while (!rd[LLKI_CTRLSTS_RESP_BIT] && polls < POLL_LIMIT) begin
      bus_read(LLKI_CTRLSTS_ADDR, 1'b0, rd);
      polls++;
    end
    if (!rd[LLKI_CTRLSTS_RESP_BIT]) begin
      $display("No response became waiting within %0d polls at %0t ns", POLL_LIMIT, $time);
      err_cnt++;
    end
  endtask

  task automatic check_response(input logic [7:0] exp_id, input logic [7:0] exp_status);
    logic [LLKI_DATA_W-1:0] rd;
    wait_response();
    bus_read(LLKI_SENDRECV_ADDR, 1'b0, rd);
    assert (rd == make_hdr(exp_id, exp_status, 16'd1))
      else report_mismatch($sformatf("response %h, expected ID %h status %h", rd,
        exp_id, exp_status));
  endtask

  task automatic wait_key_complete();
    int cycles;
    cycles = 0;
    while (!key_sts.key_complete && cycles < POLL_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!key_sts.key_complete) begin
      $display("Key never completed within %0d cycles at %0t ns", POLL_LIMIT, $time);
      err_cnt++;
    end
  endtask

  task automatic finish_test(input string name);
    test_cnt++;
    if (total_errors() != test_err_base) begin
      fail_cnt++;
      $display("Test %0d %s: failed", test_cnt, name);
    end else begin
      $display("Test %0d %s: passed", test_cnt, name);
    end
    test_err_base = total_errors();
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    logic [LLKI_DATA_W-1:0] k0;
    logic [LLKI_DATA_W-1:0] k1;
    logic [LLKI_DATA_W-1:0] k2;
    logic [LLKI_DATA_W-1:0] rd;
    int                     base;
    int                     clears;
    void'($urandom(49166));
    bus_req = '0;
    rst     = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    send_msg(KEY_STATUS_REQ, 16'd1);
    check_response(KEY_STATUS_RESP, KEY_NOT_PRESENT);
    finish_test("status without key");

    base = seen_words.size();
    k0   = {$urandom, $urandom};
    k1   = {$urandom, $urandom};
    send_msg(LOAD_KEY_REQ, 16'd3);
    bus_write(LLKI_SENDRECV_ADDR, k0, 1'b0);
    bus_write(LLKI_SENDRECV_ADDR, k1, 1'b0);
    check_response(LOAD_KEY_ACK, GOOD);
    assert (seen_words.size() == base + 2 && seen_words[base] == k0 && seen_words[base + 1] == k1)
      else report_mismatch("key words on the port differ from the words sent");
    send_msg(KEY_STATUS_REQ, 16'd1);
    check_response(KEY_STATUS_RESP, KEY_PRESENT);
    finish_test("load key");

    clears = clear_events;
    send_msg(LOAD_KEY_REQ, 16'd3);
    check_response(ERROR_RESP, KEY_OVERWRITE);
    send_msg(CLEAR_KEY_REQ, 16'd1);
    check_response(CLEAR_KEY_ACK, GOOD);
    assert (clear_events == clears + 1)
      else report_mismatch("clear_key handshake did not run once");
    finish_test("overwrite and clear");

    clears = clear_events;
    send_msg(UNKNOWN_ID, 16'd1);
    check_response(ERROR_RESP, BAD_MSG_ID);
    send_msg(CLEAR_KEY_REQ, 16'd2);
    check_response(ERROR_RESP, BAD_MSG_LEN);
    assert (clear_events == clears) else report_mismatch("clear_key raised on a bad request");
    finish_test("bad ID and length");

    base = seen_words.size();
    send_msg(LOAD_KEY_REQ, 16'd3);
    ready_en = 1'b0;
    bus_write(LLKI_SENDRECV_ADDR, k0, 1'b0);
    check_response(ERROR_RESP, LOSS_OF_SYNC);
    ready_en = 1'b1;
    assert (seen_words.size() == base) else report_mismatch("key word passed while not ready");
    // Three words for a two-word key
    clears = clear_events;
    k2     = {$urandom, $urandom};
    send_msg(LOAD_KEY_REQ, 16'd4);
    bus_write(LLKI_SENDRECV_ADDR, k0, 1'b0);
    bus_write(LLKI_SENDRECV_ADDR, k1, 1'b0);
    wait_key_complete();
    bus_write(LLKI_SENDRECV_ADDR, k2, 1'b0);
    check_response(ERROR_RESP, BAD_KEY_LEN);
    assert (clear_events == clears + 1 && !key_sts.key_complete)
      else report_mismatch("key not cleared before BAD_KEY_LEN response");
    finish_test("sync and key length");

    bus_write(UNMAPPED_ADDR, {$urandom, $urandom}, 1'b1);
    bus_read(UNMAPPED_ADDR, 1'b1, rd);
    assert (rd == '0) else report_mismatch($sformatf("unmapped read data %h", rd));
    bus_read(LLKI_CTRLSTS_ADDR, 1'b0, rd);
    assert (rd == ctrlsts_word(1'b1, 1'b0)) else report_mismatch($sformatf("idle status %h", rd));
    bus_read(LLKI_SENDRECV_ADDR, 1'b0, rd);
    assert (rd == '0) else report_mismatch($sformatf("empty buffer read %h", rd));
    send_msg(KEY_STATUS_REQ, 16'd1);
    wait_response();
    ready_en = 1'b0;
    repeat (2) @(negedge clk);
    bus_read(LLKI_CTRLSTS_ADDR, 1'b0, rd);
    assert (rd == ctrlsts_word(1'b0, 1'b1)) else report_mismatch($sformatf("busy status %h", rd));
    ready_en = 1'b1;
    check_response(KEY_STATUS_RESP, KEY_NOT_PRESENT);
    finish_test("unmapped and status reads");

    $display("Summary: %0d tests, %0d failed, %0d errors", test_cnt, fail_cnt, total_errors());
    if (total_errors() == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Watchdog sized from the test count
  initial begin
    repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
    $display("Watchdog expired after %0d cycles, tests did not finish",
      NUM_TESTS * CYCLES_PER_TEST);
    $display("TB FAILED");
    $finish;
  end

endmodule

/* llki_pp.f */
verilog/llki_pkg.sv
verilog/llki_reg_decode.sv
verilog/llki_msg_fsm.sv
verilog/llki_pp.sv
tests/llki_pp_props.sv
tests/llki_pp_tb.sv

/* Makefile */
# Verilator build and run of the LLKI protocol processor testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = llki_pp_tb
FILELIST = llki_pp.f
BUILDDIR = obj_dir
SIM      = $(BUILDDIR)/V$(TOP)
PASS_MSG = TB PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with $(TOOL) and run $(TOP), fail unless the pass line appears"
	@echo "  clean  remove the build directory"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILDDIR) -f $(FILELIST)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILDDIR)
